// ==== include/rf_params.svh ====
`ifndef RF_PARAMS_SVH
`define RF_PARAMS_SVH

// Word and address geometry
`define RF_DATA_W        64
`define RF_ADDR_W        10
`define RF_RAM_DEPTH     256
`define RF_RAM_ADDR_W    8

// Signed 16-bit lanes per word
`define RF_LANES         4

// Memory-mapped unit windows, instance n sits at base + n
`define RF_ADDR_RELU_X   10'h200
`define RF_ADDR_RELU_Y   10'h208
`define RF_ADDR_SQR_X    10'h210
`define RF_ADDR_SQR_Y    10'h218

`define RF_UNITS_PER_KIND 2

`endif

// ==== verilog/rf_pkg.sv ====
`default_nettype none

package rf_pkg;

    `include "rf_params.svh"

    localparam int LANE_W = `RF_DATA_W / `RF_LANES;

    ////////////////////////////////////////
    // Register-file word and address
    ////////////////////////////////////////
    typedef logic [`RF_DATA_W-1:0] rf_data_t;
    typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

    ////////////////////////////////////////
    // Lane view of one word
    ////////////////////////////////////////
    typedef logic signed [LANE_W-1:0] lane_t;

    // Lane 0 lives in the low bits
    typedef lane_t [`RF_LANES-1:0] lane_vec_t;

endpackage

`default_nettype wire

// ==== verilog/rf_intf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_params.svh"

////////////////////////////////////////
// One word port of a RAM-like target
////////////////////////////////////////
interface bram_intf #(
    parameter int ADDR_W = `RF_ADDR_W
);
    import rf_pkg::*;

    logic [ADDR_W-1:0] addr;
    rf_data_t          data;
    logic              we;
    logic              re;
    // Valid one cycle after re
    rf_data_t          q;

    modport master (output addr, data, we, re, input q);
    modport slave  (input addr, data, we, re, output q);
endinterface

////////////////////////////////////////
// Memory-mapped execution unit port
////////////////////////////////////////
interface rmio_intf;
    import rf_pkg::*;

    rf_data_t input_data;
    logic     input_we;
    logic     output_re;
    rf_data_t output_data;

    modport rf (output input_data, input_we, output_re, input output_data);
    modport eu (input input_data, input_we, output_re, output output_data);
endinterface

`default_nettype wire

// ==== verilog/bram_1rw.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_params.svh"

module bram_1rw (
    input  logic     clk,
    bram_intf.slave  port
);
    import rf_pkg::*;

    rf_data_t mem_array [`RF_RAM_DEPTH];

    // Write-first is not needed, host never reads and writes together
    always_ff @(posedge clk) begin
        if (port.we) begin
            mem_array[port.addr] <= port.data;
        end
    end

    // Registered read, q holds between reads
    always_ff @(posedge clk) begin
        if (port.re) begin
            port.q <= mem_array[port.addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rf_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_params.svh"

module rf_ram (
    input  logic     clk,
    input  logic     rst_n,
    bram_intf.slave  ram,
    bram_intf.master mem,
    rmio_intf.rf     rmio [2*`RF_UNITS_PER_KIND]
);
    import rf_pkg::*;

    localparam int NUM_UNITS = 2 * `RF_UNITS_PER_KIND;

    logic                 is_ram_addr;
    rf_addr_t             addr_q;
    logic                 is_ram_q;
    logic [NUM_UNITS-1:0] unit_hit_q;
    rf_data_t             unit_q [NUM_UNITS];
    rf_data_t             unit_sel;

    ////////////////////////////////////////
    // Backing RAM
    ////////////////////////////////////////
    assign is_ram_addr = ram.addr < rf_addr_t'(`RF_RAM_DEPTH);

    assign mem.addr = ram.addr[`RF_RAM_ADDR_W-1:0];
    assign mem.data = ram.data;
    assign mem.we   = ram.we && is_ram_addr;
    assign mem.re   = ram.re && is_ram_addr;

    ////////////////////////////////////////
    // Unit decode
    ////////////////////////////////////////
    // Relu instances first, then the square instances
    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
        localparam rf_addr_t X_ADDR = (i < `RF_UNITS_PER_KIND) ?
            rf_addr_t'(`RF_ADDR_RELU_X + i) :
            rf_addr_t'(`RF_ADDR_SQR_X + i - `RF_UNITS_PER_KIND);
        localparam rf_addr_t Y_ADDR = (i < `RF_UNITS_PER_KIND) ?
            rf_addr_t'(`RF_ADDR_RELU_Y + i) :
            rf_addr_t'(`RF_ADDR_SQR_Y + i - `RF_UNITS_PER_KIND);

        // Write data goes to every unit, only the enable is decoded
        assign rmio[i].input_data = ram.data;
        assign rmio[i].input_we   = ram.we && (ram.addr == X_ADDR);
        assign rmio[i].output_re  = ram.re && (ram.addr == Y_ADDR);

        assign unit_q[i]     = rmio[i].output_data;
        assign unit_hit_q[i] = (addr_q == Y_ADDR);
    end

    ////////////////////////////////////////
    // Read address, lines up with the RAM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (ram.re) begin
            addr_q <= ram.addr;
        end
    end

    assign is_ram_q = addr_q < rf_addr_t'(`RF_RAM_DEPTH);

    // At most one unit matches the stored address
    always_comb begin
        unit_sel = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (unit_hit_q[i]) begin
                unit_sel = unit_q[i];
            end
        end
    end

    // Unmapped reads fall through to zero
    always_comb begin
        if (is_ram_q) begin
            ram.q = mem.q;
        end else begin
            ram.q = unit_sel;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/relu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_params.svh"

module relu_unit (
    input  logic clk,
    input  logic rst_n,
    rmio_intf.eu io
);
    import rf_pkg::*;

    lane_vec_t operand;
    lane_vec_t relu_vec;
    lane_vec_t result_q;

    assign operand = io.input_data;

    // Negative lanes clamp to zero
    always_comb begin
        for (int i = 0; i < `RF_LANES; i++) begin
            if (operand[i] < 0) begin
                relu_vec[i] = '0;
            end else begin
                relu_vec[i] = operand[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
        end else if (io.input_we) begin
            result_q <= relu_vec;
        end
    end

    // Read port, one cycle of latency
    always_ff @(posedge clk) begin
        if (io.output_re) begin
            io.output_data <= result_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/square_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_params.svh"

module square_unit (
    input  logic clk,
    input  logic rst_n,
    rmio_intf.eu io
);
    import rf_pkg::*;

    localparam lane_t LANE_MAX = lane_t'(2**(LANE_W-1) - 1);

    lane_vec_t                  operand;
    lane_vec_t                  sq_vec;
    lane_vec_t                  result_q;
    logic signed [2*LANE_W-1:0] sq_full;

    assign operand = io.input_data;

    ////////////////////////////////////////
    // Lane squares with saturation
    ////////////////////////////////////////
    // Square of -32768 is 2**30, still positive in 32 bits
    always_comb begin
        sq_full = '0;
        for (int i = 0; i < `RF_LANES; i++) begin
            sq_full = operand[i] * operand[i];
            if (sq_full > LANE_MAX) begin
                sq_vec[i] = LANE_MAX;
            end else begin
                sq_vec[i] = sq_full[LANE_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
        end else if (io.input_we) begin
            result_q <= sq_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (io.output_re) begin
            io.output_data <= result_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_port (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  logic             req_write,
    input  rf_pkg::rf_addr_t req_addr,
    input  rf_pkg::rf_data_t req_wdata,
    output logic             req_ready,
    output logic             resp_valid,
    input  logic             resp_ready,
    output rf_pkg::rf_data_t resp_rdata,
    bram_intf.master         rf
);

    typedef enum logic {
        ST_IDLE,
        ST_READ
    } state_t;

    state_t state;
    logic   req_fire;
    logic   resp_fire;

    ////////////////////////////////////////
    // Request side
    ////////////////////////////////////////
    assign resp_fire = resp_valid && resp_ready;

    // A response leaving this cycle frees the port at once
    assign req_ready = (state == ST_IDLE) && (!resp_valid || resp_ready);
    assign req_fire  = req_valid && req_ready;

    // Access goes out in the same cycle the request is accepted
    assign rf.addr = req_addr;
    assign rf.data = req_wdata;
    assign rf.we   = req_fire && req_write;
    assign rf.re   = req_fire && !req_write;

    ////////////////////////////////////////
    // Read tracking and response hold
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            resp_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rf.re) begin
                        state <= ST_READ;
                    end
                    if (resp_fire) begin
                        resp_valid <= 1'b0;
                    end
                end
                ST_READ: begin
                    // Selected data is valid now
                    state      <= ST_IDLE;
                    resp_valid <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_READ) begin
            resp_rdata <= rf.q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rf_mmio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_params.svh"

module rf_mmio_top (
    input  logic             clk,
    input  logic             rst_n,

    // Request channel
    input  logic             req_valid,
    output logic             req_ready,
    input  logic             req_write,
    input  rf_pkg::rf_addr_t req_addr,
    input  rf_pkg::rf_data_t req_wdata,

    // Read response channel
    output logic             resp_valid,
    input  logic             resp_ready,
    output rf_pkg::rf_data_t resp_rdata
);

    localparam int NUM_UNITS = 2 * `RF_UNITS_PER_KIND;

    bram_intf                             host_bus ();
    bram_intf #(.ADDR_W(`RF_RAM_ADDR_W))  ram_bus ();
    rmio_intf                             unit_bus [NUM_UNITS] ();

    host_port u_host_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .rf         (host_bus)
    );

    rf_ram u_rf_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .ram   (host_bus),
        .mem   (ram_bus),
        .rmio  (unit_bus)
    );

    bram_1rw u_bram (
        .clk  (clk),
        .port (ram_bus)
    );

    ////////////////////////////////////////
    // Execution units
    ////////////////////////////////////////
    for (genvar i = 0; i < `RF_UNITS_PER_KIND; i++) begin : g_relu
        relu_unit u_relu (
            .clk   (clk),
            .rst_n (rst_n),
            .io    (unit_bus[i])
        );
    end

    // Square units take the upper half of the unit ports
    for (genvar i = 0; i < `RF_UNITS_PER_KIND; i++) begin : g_square
        square_unit u_square (
            .clk   (clk),
            .rst_n (rst_n),
            .io    (unit_bus[i + `RF_UNITS_PER_KIND])
        );
    end

endmodule

`default_nettype wire

// ==== tests/rf_mmio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_params.svh"

module rf_mmio_tb;
    import rf_pkg::*;

    localparam int UPK          = `RF_UNITS_PER_KIND;
    localparam int NUM_UNITS    = 2 * `RF_UNITS_PER_KIND;
    localparam int NUM_TESTS    = 6;
    localparam int OPS_PER_TEST = 64;
    localparam int WAIT_LIMIT   = 100;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    logic     req_ready;
    logic     req_write;
    rf_addr_t req_addr;
    rf_data_t req_wdata;
    logic     resp_valid;
    logic     resp_ready;
    rf_data_t resp_rdata;

    logic [31:0] lcg_state;
    rf_data_t    shadow_ram [`RF_RAM_DEPTH];
    rf_data_t    shadow_unit [NUM_UNITS];
    rf_data_t    exp_q [$];
    int          error_count;
    int          test_count;
    int          pass_count;
    int          errors_at_start;
    string       test_name;

    rf_mmio_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rf_data_t rand_word();
        rf_data_t w;
        w[63:32] = lcg_next();
        w[31:0]  = lcg_next();
        return w;
    endfunction

    function automatic rf_addr_t x_addr(input int n);
        return (n < UPK) ? rf_addr_t'(`RF_ADDR_RELU_X + n) : rf_addr_t'(`RF_ADDR_SQR_X + n - UPK);
    endfunction

    function automatic rf_addr_t y_addr(input int n);
        return (n < UPK) ? rf_addr_t'(`RF_ADDR_RELU_Y + n) : rf_addr_t'(`RF_ADDR_SQR_Y + n - UPK);
    endfunction

    function automatic rf_data_t relu_ref(input rf_data_t d);
        rf_data_t r;
        int       s;
        for (int i = 0; i < `RF_LANES; i++) begin
            s = $signed(d[16*i +: 16]);
            r[16*i +: 16] = (s < 0) ? 16'h0000 : d[16*i +: 16];
        end
        return r;
    endfunction

    // Squares above the lane maximum saturate
    function automatic rf_data_t square_ref(input rf_data_t d);
        rf_data_t r;
        int       s;
        int       sq;
        for (int i = 0; i < `RF_LANES; i++) begin
            s  = $signed(d[16*i +: 16]);
            sq = s * s;
            if (sq > 32767) begin
                sq = 32767;
            end
            r[16*i +: 16] = sq[15:0];
        end
        return r;
    endfunction

    function automatic void ref_write(input rf_addr_t addr, input rf_data_t d);
        if (addr < `RF_RAM_DEPTH) begin
            shadow_ram[addr[`RF_RAM_ADDR_W-1:0]] = d;
        end
        for (int n = 0; n < NUM_UNITS; n++) begin
            if (addr == x_addr(n)) begin
                shadow_unit[n] = (n < UPK) ? relu_ref(d) : square_ref(d);
            end
        end
    endfunction

    // Only RAM words and unit Y addresses return data
    function automatic rf_data_t ref_read(input rf_addr_t addr);
        if (addr < `RF_RAM_DEPTH) begin
            return shadow_ram[addr[`RF_RAM_ADDR_W-1:0]];
        end
        for (int n = 0; n < NUM_UNITS; n++) begin
            if (addr == y_addr(n)) begin
                return shadow_unit[n];
            end
        end
        return '0;
    endfunction

    ////////////////////////////////////////
    // Compare tasks and test bookkeeping
    ////////////////////////////////////////
    task automatic check_data(input string name, input rf_data_t act, input rf_data_t exp);
        if (act !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, act, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, act, exp);
            error_count++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic end_test();
        int errs;
        errs = error_count - errors_at_start;
        if (errs == 0) begin
            pass_count++;
            $display("Test %0d %s: PASS", test_count, test_name);
        end else begin
            $display("Test %0d %s: FAIL with %0d errors", test_count, test_name, errs);
        end
    endtask

    ////////////////////////////////////////
    // Host request driver
    ////////////////////////////////////////
    // Leaves req_valid high so writes can go back to back
    task automatic send_req(input logic write, input rf_addr_t addr, input rf_data_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        @(posedge clk);
        while (!req_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!req_ready) begin
            $display("Request to address %h was never accepted", addr);
            error_count++;
        end
    endtask

    task automatic write_word(input rf_addr_t addr, input rf_data_t data);
        send_req(1'b1, addr, data);
        ref_write(addr, data);
    endtask

    task automatic read_word(input rf_addr_t addr);
        send_req(1'b0, addr, '0);
        exp_q.push_back(ref_read(addr));
    endtask

    task automatic release_req();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // Wait until every read has been answered
    task automatic drain();
        int waited;
        waited = 0;
        release_req();
        while ((exp_q.size() != 0 || resp_valid) && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("%0d read responses never arrived", exp_q.size());
            error_count++;
        end
    endtask

    task automatic wait_resp_valid();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!resp_valid && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!resp_valid) begin
            $display("Read response never became valid");
            error_count++;
        end
    endtask

    // Response monitor
    always @(posedge clk) begin
        if (rst_n && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Response arrived with no read outstanding at %0t ns", $time);
                error_count++;
            end else begin
                check_data("resp_rdata", resp_rdata, exp_q.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        repeat (NUM_TESTS * OPS_PER_TEST * 20) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles",
                 NUM_TESTS * OPS_PER_TEST * 20);
        $display("tests failed");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        rf_data_t    held;
        rf_addr_t    addr;
        rf_addr_t    addr_list [$];
        logic [31:0] r;
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        resp_ready  = 1'b1;
        lcg_state   = 32'hc367_a7dd;
        error_count = 0;
        test_count  = 0;
        pass_count  = 0;
        for (int n = 0; n < NUM_UNITS; n++) begin
            shadow_unit[n] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        begin_test("unit results after reset");
        check_flag("resp_valid", resp_valid, 1'b0);
        check_flag("req_ready", req_ready, 1'b1);
        for (int n = 0; n < NUM_UNITS; n++) begin
            read_word(y_addr(n));
        end
        drain();
        end_test();

        begin_test("ram write and read back");
        for (int i = 0; i < 24; i++) begin
            r    = lcg_next();
            addr = rf_addr_t'(r[7:0]);
            addr_list.push_back(addr);
            write_word(addr, rand_word());
        end
        foreach (addr_list[i]) begin
            read_word(addr_list[i]);
        end
        drain();
        end_test();

        begin_test("relu units");
        check_data("relu_ref", relu_ref(64'h8000_7fff_ffff_0001), 64'h0000_7fff_0000_0001);
        for (int n = 0; n < UPK; n++) begin
            write_word(x_addr(n), rand_word());
            read_word(y_addr(n));
        end
        write_word(x_addr(1), 64'h8000_7fff_ffff_0001);
        for (int n = 0; n < NUM_UNITS; n++) begin
            read_word(y_addr(n));
        end
        drain();
        end_test();

        begin_test("square units");
        // Lanes -32768, 200, 181, -3 from high to low
        check_data("square_ref", square_ref(64'h8000_00c8_00b5_fffd), 64'h7fff_7fff_7ff9_0009);
        write_word(x_addr(UPK), 64'h8000_00c8_00b5_fffd);
        write_word(x_addr(UPK + 1), rand_word());
        for (int n = 0; n < NUM_UNITS; n++) begin
            read_word(y_addr(n));
        end
        drain();
        end_test();

        begin_test("unmapped addresses");
        write_word(10'h000, rand_word());
        read_word(10'h300);
        // 0x300 aliases RAM word 0 in the low bits
        write_word(10'h300, rand_word());
        write_word(10'h3ff, rand_word());
        read_word(10'h000);
        read_word(10'h300);
        read_word(x_addr(0));
        for (int n = 0; n < NUM_UNITS; n++) begin
            read_word(y_addr(n));
        end
        drain();
        end_test();

        begin_test("response back-pressure");
        write_word(10'h055, rand_word());
        drain();
        resp_ready = 1'b0;
        read_word(10'h055);
        release_req();
        wait_resp_valid();
        held = ref_read(10'h055);
        repeat (5) begin
            @(posedge clk);
            check_flag("resp_valid", resp_valid, 1'b1);
            check_data("resp_rdata", resp_rdata, held);
            check_flag("req_ready", req_ready, 1'b0);
        end
        @(negedge clk);
        resp_ready = 1'b1;
        // Port frees up on the transfer edge itself
        @(posedge clk);
        check_flag("req_ready", req_ready, 1'b1);
        read_word(10'h055);
        drain();
        end_test();

        $display("Ran %0d tests, %0d passed, %0d with errors, %0d errors in all",
                 test_count, pass_count, test_count - pass_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rf_mmio_top.f ====
+incdir+include
verilog/rf_pkg.sv
verilog/rf_intf.sv
verilog/bram_1rw.sv
verilog/rf_ram.sv
verilog/relu_unit.sv
verilog/square_unit.sv
verilog/host_port.sv
verilog/rf_mmio_top.sv
tests/rf_mmio_tb.sv
